// ==== fused_config.svh ====
`ifndef FUSED_CONFIG_SVH
`define FUSED_CONFIG_SVH

// int8 channels packed in one memory word
`define LANES 4

// Global memory geometry
`define GMEM_AW 8
`define GMEM_DEPTH 256

// Queue depths, which are also the initial credit counts
`define PIX_CREDITS 2
`define WB_CREDITS 4

// Upper clamp of the layer 1 activation
`define RELU_MAX 6

`endif

// ==== fused_pkg.sv ====
`include "fused_config.svh"

package fused_pkg;

    typedef logic signed [7:0] lane_t;             // One int8 channel
    typedef logic [`LANES*8-1:0] word_t;           // Lane k sits in byte k
    typedef logic signed [31:0] acc_t;
    typedef logic [`GMEM_AW-1:0] gmem_addr_t;
    typedef logic [7:0] count_t;

    typedef struct packed {
        gmem_addr_t weight_base;
        gmem_addr_t ifm_base;
        gmem_addr_t ofm_base;
        count_t     num_pixels;
    } job_cfg_t;

    typedef struct packed {
        logic       valid;
        logic       write;
        gmem_addr_t addr;
        word_t      data;
    } mem_req_t;

    typedef struct packed {
        logic  valid;
        word_t data;
    } mem_rsp_t;

    typedef struct packed {
        logic       valid;
        logic [2:0] index;                         // 0..3 layer 1, 4..7 layer 2
        word_t      data;
    } weight_wr_t;

    typedef struct packed {
        logic  valid;
        word_t data;
    } flit_t;

    typedef enum logic [1:0] {
        IDLE,
        LOAD_W,
        STREAM
    } fetch_state_t;

endpackage

// ==== global_mem.sv ====
`include "fused_config.svh"

module global_mem (
    input  logic                clk,
    input  fused_pkg::mem_req_t req,
    output fused_pkg::word_t    rdata
);

    fused_pkg::word_t mem [`GMEM_DEPTH];

    // Single port, write or read each cycle
    always_ff @(posedge clk) begin
        if (req.valid) begin
            if (req.write) begin
                mem[req.addr] <= req.data;
            end else begin
                rdata <= mem[req.addr];   // Visible in the next cycle
            end
        end
    end

endmodule

// ==== gmem_arbiter.sv ====
module gmem_arbiter (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                load_phase,
    input  fused_pkg::mem_req_t host_req,
    output fused_pkg::mem_rsp_t host_rsp,
    input  fused_pkg::mem_req_t fetch_req,
    output logic                fetch_gnt,
    output fused_pkg::mem_rsp_t fetch_rsp,
    input  fused_pkg::mem_req_t wb_req,
    output logic                wb_gnt
);

    fused_pkg::mem_req_t mem_req;
    fused_pkg::word_t    rdata;
    logic                host_sel;
    logic                wb_first;     // Round-robin pointer, writer wins a tie
    logic                rd_pending;
    logic                rd_host;      // Owner tag of the read in flight

    global_mem u_mem (
        .clk   (clk),
        .req   (mem_req),
        .rdata (rdata)
    );

    always_comb begin
        host_sel  = load_phase && host_req.valid;
        fetch_gnt = 1'b0;
        wb_gnt    = 1'b0;
        if (!load_phase) begin
            if (fetch_req.valid && !(wb_req.valid && wb_first)) begin
                fetch_gnt = 1'b1;
            end else if (wb_req.valid) begin
                wb_gnt = 1'b1;
            end
        end
        if (host_sel) begin
            mem_req = host_req;
        end else if (fetch_gnt) begin
            mem_req = fetch_req;
        end else if (wb_gnt) begin
            mem_req = wb_req;
        end else begin
            mem_req = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_pending <= 1'b0;
            rd_host    <= 1'b0;
            wb_first   <= 1'b0;
        end else begin
            rd_pending <= mem_req.valid && !mem_req.write;
            rd_host    <= host_sel;
            if (fetch_gnt) begin
                wb_first <= 1'b1;   // Other side goes first next time
            end else if (wb_gnt) begin
                wb_first <= 1'b0;
            end
        end
    end

    // Read data goes back only to the owner of the read
    always_comb begin
        host_rsp.valid  = rd_pending && rd_host;
        host_rsp.data   = rdata;
        fetch_rsp.valid = rd_pending && !rd_host;
        fetch_rsp.data  = rdata;
    end

endmodule

// ==== fetch_unit.sv ====
`include "fused_config.svh"

module fetch_unit (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  fused_pkg::job_cfg_t   cfg,
    output fused_pkg::mem_req_t   mem_req,
    input  logic                  mem_gnt,
    input  fused_pkg::mem_rsp_t   mem_rsp,
    output fused_pkg::weight_wr_t weight_wr,
    output fused_pkg::flit_t      pix,
    input  logic                  pix_credit,
    output logic                  busy
);

    localparam int CW = $clog2(`PIX_CREDITS + 1);

    fused_pkg::fetch_state_t state;
    fused_pkg::gmem_addr_t   rd_addr;
    fused_pkg::gmem_addr_t   ifm_base_q;
    fused_pkg::count_t       pix_left;     // Pixel reads still to issue
    logic [2:0]              w_idx;        // Index of the next weight word back
    logic                    pending;      // One read outstanding
    logic [CW-1:0]           credits;

    always_comb begin
        mem_req.valid = !pending && ((state == fused_pkg::LOAD_W) ||
                        (state == fused_pkg::STREAM && pix_left != '0 && credits != '0));
        mem_req.write = 1'b0;
        mem_req.addr  = rd_addr;
        mem_req.data  = '0;

        weight_wr.valid = mem_rsp.valid && (state == fused_pkg::LOAD_W);
        weight_wr.index = w_idx;
        weight_wr.data  = mem_rsp.data;

        pix.valid = mem_rsp.valid && (state == fused_pkg::STREAM);
        pix.data  = mem_rsp.data;

        busy = (state != fused_pkg::IDLE);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= fused_pkg::IDLE;
            pix_left <= '0;
            w_idx    <= '0;
            pending  <= 1'b0;
            credits  <= CW'(`PIX_CREDITS);
        end else begin
            credits <= credits + CW'(pix_credit) - CW'(pix.valid);
            if (mem_gnt) begin
                pending <= 1'b1;
                if (state == fused_pkg::STREAM) begin
                    pix_left <= pix_left - 1'b1;
                end
            end
            if (mem_rsp.valid) begin
                pending <= 1'b0;
            end
            case (state)
                fused_pkg::IDLE: begin
                    if (start) begin
                        state    <= fused_pkg::LOAD_W;
                        pix_left <= cfg.num_pixels;
                        w_idx    <= '0;
                    end
                end
                fused_pkg::LOAD_W: begin
                    if (mem_rsp.valid) begin
                        w_idx <= w_idx + 1'b1;
                        if (w_idx == 3'd7) begin
                            state <= (pix_left == '0) ? fused_pkg::IDLE : fused_pkg::STREAM;
                        end
                    end
                end
                default: begin
                    if (mem_rsp.valid && pix_left == '0) begin
                        state <= fused_pkg::IDLE;   // Last pixel forwarded
                    end
                end
            endcase
        end
    end

    // Read address walks the weights, then restarts at the pixel base
    always_ff @(posedge clk) begin
        if (state == fused_pkg::IDLE && start) begin
            rd_addr    <= cfg.weight_base;
            ifm_base_q <= cfg.ifm_base;
        end else if (mem_gnt) begin
            rd_addr <= rd_addr + 1'b1;
        end else if (state == fused_pkg::LOAD_W && mem_rsp.valid && w_idx == 3'd7) begin
            rd_addr <= ifm_base_q;
        end
    end

endmodule

// ==== pointwise_mac.sv ====
`include "fused_config.svh"

module pointwise_mac (
    input  fused_pkg::word_t x,
    input  fused_pkg::word_t filt [`LANES],
    output fused_pkg::acc_t  acc  [`LANES]
);

    // One dot product per filter over all input channels
    always_comb begin
        for (int f = 0; f < `LANES; f++) begin
            acc[f] = '0;
            for (int c = 0; c < `LANES; c++) begin
                acc[f] = acc[f] + fused_pkg::lane_t'(x[c*8 +: 8]) *
                                  fused_pkg::lane_t'(filt[f][c*8 +: 8]);
            end
        end
    end

endmodule

// ==== pointwise_engine.sv ====
`include "fused_config.svh"

module pointwise_engine (
    input  logic                  clk,
    input  logic                  rst_n,
    input  fused_pkg::weight_wr_t weight_wr,
    input  fused_pkg::flit_t      pix,
    output logic                  pix_credit,
    output fused_pkg::flit_t      res,
    input  logic                  res_credit
);

    localparam int PD = `PIX_CREDITS;
    localparam int PW = $clog2(PD);
    localparam int CW = $clog2(`WB_CREDITS + 1);

    fused_pkg::word_t          w1 [`LANES];
    fused_pkg::word_t          w2 [`LANES];
    fused_pkg::word_t          pq [PD];
    logic [PW-1:0]             pq_wr;
    logic [PW-1:0]             pq_rd;
    logic [$clog2(PD+1)-1:0]   pq_cnt;
    logic [CW-1:0]             wb_credits;
    logic                      pop;
    fused_pkg::acc_t           acc1 [`LANES];
    fused_pkg::acc_t           acc2 [`LANES];
    fused_pkg::word_t          s1_next;
    fused_pkg::word_t          s2_next;
    logic                      s1_valid;
    fused_pkg::word_t          s1_data;
    logic                      res_valid_q;
    fused_pkg::word_t          res_data_q;

    // Pop only with a writer slot reserved, so nothing stalls after this
    assign pop        = (pq_cnt != '0) && (wb_credits != '0);
    assign pix_credit = pop;

    pointwise_mac u_mac_l1 (
        .x    (pq[pq_rd]),
        .filt (w1),
        .acc  (acc1)
    );

    pointwise_mac u_mac_l2 (
        .x    (s1_data),
        .filt (w2),
        .acc  (acc2)
    );

    always_comb begin
        for (int k = 0; k < `LANES; k++) begin
            if (acc1[k] < 0) begin
                s1_next[k*8 +: 8] = 8'd0;
            end else if (acc1[k] > `RELU_MAX) begin
                s1_next[k*8 +: 8] = 8'(`RELU_MAX);        // ReLU6 ceiling
            end else begin
                s1_next[k*8 +: 8] = acc1[k][7:0];
            end
            if (acc2[k] > 127) begin
                s2_next[k*8 +: 8] = 8'h7f;
            end else if (acc2[k] < -128) begin
                s2_next[k*8 +: 8] = 8'h80;
            end else begin
                s2_next[k*8 +: 8] = acc2[k][7:0];
            end
        end
        res.valid = res_valid_q;
        res.data  = res_data_q;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pq_wr       <= '0;
            pq_rd       <= '0;
            pq_cnt      <= '0;
            wb_credits  <= CW'(`WB_CREDITS);
            s1_valid    <= 1'b0;
            res_valid_q <= 1'b0;
        end else begin
            if (pix.valid) begin
                pq_wr <= (pq_wr == PW'(PD - 1)) ? '0 : pq_wr + 1'b1;
            end
            if (pop) begin
                pq_rd <= (pq_rd == PW'(PD - 1)) ? '0 : pq_rd + 1'b1;
            end
            pq_cnt      <= pq_cnt + pix.valid - pop;
            wb_credits  <= wb_credits + CW'(res_credit) - CW'(pop);
            s1_valid    <= pop;
            res_valid_q <= s1_valid;
        end
    end

    // Weights, queue slots and stage data
    always_ff @(posedge clk) begin
        if (weight_wr.valid) begin
            if (weight_wr.index[2]) begin
                w2[weight_wr.index[1:0]] <= weight_wr.data;
            end else begin
                w1[weight_wr.index[1:0]] <= weight_wr.data;
            end
        end
        if (pix.valid) begin
            pq[pq_wr] <= pix.data;
        end
        s1_data    <= s1_next;
        res_data_q <= s2_next;
    end

endmodule

// ==== result_writer.sv ====
`include "fused_config.svh"

module result_writer (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    input  fused_pkg::job_cfg_t cfg,
    input  fused_pkg::flit_t    res,
    output logic                res_credit,
    output fused_pkg::mem_req_t mem_req,
    input  logic                mem_gnt,
    output logic                done
);

    localparam int QD = `WB_CREDITS;
    localparam int QW = $clog2(QD);

    fused_pkg::word_t        wq [QD];
    logic [QW-1:0]           wq_wr;
    logic [QW-1:0]           wq_rd;
    logic [$clog2(QD+1)-1:0] wq_cnt;
    fused_pkg::count_t       wr_count;     // Results written in this job
    fused_pkg::gmem_addr_t   ofm_q;
    fused_pkg::count_t       npix_q;

    // Request held until granted, each grant frees a slot
    always_comb begin
        mem_req.valid = (wq_cnt != '0);
        mem_req.write = 1'b1;
        mem_req.addr  = ofm_q + wr_count;
        mem_req.data  = wq[wq_rd];
        res_credit    = mem_gnt;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wq_wr    <= '0;
            wq_rd    <= '0;
            wq_cnt   <= '0;
            wr_count <= '0;
            done     <= 1'b0;
        end else begin
            if (res.valid) begin
                wq_wr <= (wq_wr == QW'(QD - 1)) ? '0 : wq_wr + 1'b1;
            end
            if (mem_gnt) begin
                wq_rd <= (wq_rd == QW'(QD - 1)) ? '0 : wq_rd + 1'b1;
            end
            wq_cnt <= wq_cnt + res.valid - mem_gnt;
            if (start) begin
                wr_count <= '0;
                done     <= 1'b0;
            end else if (mem_gnt) begin
                wr_count <= wr_count + 1'b1;
                if (fused_pkg::count_t'(wr_count + 1'b1) == npix_q) begin
                    done <= 1'b1;   // Last write granted
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (res.valid) begin
            wq[wq_wr] <= res.data;
        end
        if (start) begin
            ofm_q  <= cfg.ofm_base;
            npix_q <= cfg.num_pixels;
        end
    end

endmodule

// ==== fused_top.sv ====
module fused_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                load_phase,
    input  logic                start,
    input  fused_pkg::job_cfg_t cfg,
    input  fused_pkg::mem_req_t host_req,
    output fused_pkg::mem_rsp_t host_rsp,
    output logic                busy,
    output logic                done
);

    fused_pkg::mem_req_t   fetch_req;
    logic                  fetch_gnt;
    fused_pkg::mem_rsp_t   fetch_rsp;
    fused_pkg::mem_req_t   wb_req;
    logic                  wb_gnt;
    fused_pkg::weight_wr_t weight_wr;
    fused_pkg::flit_t      pix;
    logic                  pix_credit;
    fused_pkg::flit_t      res;
    logic                  res_credit;

    gmem_arbiter u_arb (
        .clk        (clk),
        .rst_n      (rst_n),
        .load_phase (load_phase),
        .host_req   (host_req),
        .host_rsp   (host_rsp),
        .fetch_req  (fetch_req),
        .fetch_gnt  (fetch_gnt),
        .fetch_rsp  (fetch_rsp),
        .wb_req     (wb_req),
        .wb_gnt     (wb_gnt)
    );

    fetch_unit u_fetch (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .cfg        (cfg),
        .mem_req    (fetch_req),
        .mem_gnt    (fetch_gnt),
        .mem_rsp    (fetch_rsp),
        .weight_wr  (weight_wr),
        .pix        (pix),
        .pix_credit (pix_credit),
        .busy       (busy)
    );

    pointwise_engine u_engine (
        .clk        (clk),
        .rst_n      (rst_n),
        .weight_wr  (weight_wr),
        .pix        (pix),
        .pix_credit (pix_credit),
        .res        (res),
        .res_credit (res_credit)
    );

    result_writer u_writer (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .cfg        (cfg),
        .res        (res),
        .res_credit (res_credit),
        .mem_req    (wb_req),
        .mem_gnt    (wb_gnt),
        .done       (done)
    );

endmodule

// ==== tb_clock_gen.sv ====
module tb_clock_gen #(
    parameter real PERIOD_NS    = 8.0,
    parameter int  RESET_CYCLES = 10
) (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;   // Released on a rising edge
    end

endmodule

// ==== fused_tb.sv ====
`include "fused_config.svh"

module fused_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam fused_pkg::count_t NPIX_A = 12;
    localparam fused_pkg::count_t NPIX_B = 40;   // Well beyond both credit depths
    localparam fused_pkg::count_t NPIX_C = 9;
    localparam fused_pkg::count_t NPIX_D = 7;
    localparam int JOB_CYCLES  = 4 * 40 + 8 * (NPIX_A + NPIX_B + NPIX_C + NPIX_D);
    localparam int HOST_CYCLES = 10 + `GMEM_DEPTH + 100 + 4 * 3 * `GMEM_DEPTH + 40;
    localparam int CYCLE_LIMIT = JOB_CYCLES + HOST_CYCLES;

    logic                clk;
    logic                rst_n;
    logic                load_phase;
    logic                start;
    logic                busy;
    logic                done;
    fused_pkg::job_cfg_t cfg;
    fused_pkg::mem_req_t host_req;
    fused_pkg::mem_rsp_t host_rsp;
    fused_pkg::word_t    shadow [`GMEM_DEPTH];   // Expected memory contents
    int                  seed;
    int                  mismatch_count;
    int                  other_count;
    int                  cycle_count;

    tb_clock_gen u_clk (
        .clk   (clk),
        .rst_n (rst_n)
    );

    fused_top dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .load_phase (load_phase),
        .start      (start),
        .cfg        (cfg),
        .host_req   (host_req),
        .host_rsp   (host_rsp),
        .busy       (busy),
        .done       (done)
    );

    // Every byte follows from the full address
    function automatic fused_pkg::word_t fill_pattern(input fused_pkg::gmem_addr_t a);
        return {a ^ 8'h5a, ~a, {a[3:0], a[7:4]}, a + 8'h11};
    endfunction

    function automatic fused_pkg::job_cfg_t make_cfg(input fused_pkg::gmem_addr_t wb,
                                                     input fused_pkg::gmem_addr_t ib,
                                                     input fused_pkg::gmem_addr_t ob,
                                                     input fused_pkg::count_t n);
        fused_pkg::job_cfg_t c;
        c.weight_base = wb;
        c.ifm_base    = ib;
        c.ofm_base    = ob;
        c.num_pixels  = n;
        return c;
    endfunction

    // Layer 1 dot products, ReLU6, layer 2 dot products, signed byte saturation
    function automatic fused_pkg::word_t model_word(input fused_pkg::word_t px,
                                                    input fused_pkg::gmem_addr_t wbase);
        int               hid [`LANES];
        int               s;
        int               a;
        int               b;
        fused_pkg::word_t w;
        fused_pkg::word_t out;
        for (int f = 0; f < `LANES; f++) begin
            w = shadow[(wbase + f) % `GMEM_DEPTH];
            s = 0;
            for (int c = 0; c < `LANES; c++) begin
                a = $signed(px[c*8 +: 8]);
                b = $signed(w[c*8 +: 8]);
                s = s + a * b;
            end
            hid[f] = (s < 0) ? 0 : ((s > `RELU_MAX) ? `RELU_MAX : s);
        end
        for (int f = 0; f < `LANES; f++) begin
            w = shadow[(wbase + `LANES + f) % `GMEM_DEPTH];   // Layer 2 filters
            s = 0;
            for (int c = 0; c < `LANES; c++) begin
                b = $signed(w[c*8 +: 8]);
                s = s + hid[c] * b;
            end
            if (s > 127) begin
                s = 127;
            end else if (s < -128) begin
                s = -128;
            end
            out[f*8 +: 8] = 8'(s);
        end
        return out;
    endfunction

    task automatic host_write(input fused_pkg::gmem_addr_t a, input fused_pkg::word_t d);
        fused_pkg::mem_req_t r;
        r.valid = 1'b1;
        r.write = 1'b1;
        r.addr  = a;
        r.data  = d;
        @(posedge clk);
        host_req <= r;
        shadow[a] = d;
    endtask

    task automatic host_read(input fused_pkg::gmem_addr_t a, output fused_pkg::word_t d);
        fused_pkg::mem_req_t r;
        r.valid = 1'b1;
        r.write = 1'b0;
        r.addr  = a;
        r.data  = '0;
        @(posedge clk);
        host_req <= r;
        @(posedge clk);
        host_req <= '0;
        @(negedge clk);   // Data is one cycle behind the grant
        assert (host_rsp.valid === 1'b1) else begin
            other_count++;
            $display("No read response for address %02h", a);
        end
        d = host_rsp.data;
    endtask

    task automatic load_random(input fused_pkg::gmem_addr_t base, input int n);
        for (int i = 0; i < n; i++) begin
            host_write(fused_pkg::gmem_addr_t'(base + i), $random(seed));
        end
    endtask

    task automatic check_memory(input string what);
        fused_pkg::word_t d;
        @(posedge clk);
        load_phase <= 1'b1;
        for (int a = 0; a < `GMEM_DEPTH; a++) begin
            host_read(fused_pkg::gmem_addr_t'(a), d);
            assert (d === shadow[a]) else begin
                mismatch_count++;
                $display("mismatch host_rsp.data (%s) addr %02h: expected %08h, actual %08h",
                         what, a, shadow[a], d);
            end
        end
    endtask

    task automatic run_job(input fused_pkg::job_cfg_t c, input logic prev_done);
        int   waited;
        logic done_before;
        @(negedge clk);
        done_before = done;
        assert (done_before === prev_done) else begin
            mismatch_count++;
            $display("mismatch done before start: expected %0h, actual %0h",
                     prev_done, done_before);
        end
        @(posedge clk);
        load_phase <= 1'b0;
        host_req   <= '0;   // No host write left pending for the readback
        cfg        <= c;
        start      <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        assert (done === 1'b0) else begin
            mismatch_count++;
            $display("mismatch done after start: expected 0, actual %0h", done);
        end
        assert (busy === 1'b1) else begin
            mismatch_count++;
            $display("mismatch busy after start: expected 1, actual %0h", busy);
        end
        waited = 0;
        while (done !== 1'b1 && waited < 40 + 8 * c.num_pixels) begin
            @(negedge clk);
            waited++;
        end
        assert (done === 1'b1) else begin
            other_count++;
            $display("The job did not signal done within %0d cycles", waited);
        end
        assert (busy === 1'b0) else begin
            mismatch_count++;
            $display("mismatch busy at done: expected 0, actual %0h", busy);
        end
        for (int i = 0; i < c.num_pixels; i++) begin
            shadow[(c.ofm_base + i) % `GMEM_DEPTH] =
                model_word(shadow[(c.ifm_base + i) % `GMEM_DEPTH], c.weight_base);
        end
    endtask

    initial begin
        seed           = 32'hde04_063e;
        mismatch_count = 0;
        other_count    = 0;
        load_phase     = 1'b0;
        start          = 1'b0;
        cfg            = '0;
        host_req       = '0;

        wait (rst_n === 1'b1);
        @(negedge clk);
        assert (busy === 1'b0 && done === 1'b0) else begin
            mismatch_count++;
            $display("mismatch busy/done after reset: expected 0/0, actual %0h/%0h",
                     busy, done);
        end

        // Whole memory gets a known pattern, then a full readback
        @(posedge clk);
        load_phase <= 1'b1;
        for (int a = 0; a < `GMEM_DEPTH; a++) begin
            host_write(fused_pkg::gmem_addr_t'(a), fill_pattern(fused_pkg::gmem_addr_t'(a)));
        end
        check_memory("fill");

        load_random(8'h00, 8);
        load_random(8'h10, NPIX_A);
        run_job(make_cfg(8'h00, 8'h10, 8'h40, NPIX_A), 1'b0);
        check_memory("random job");

        load_random(8'h08, 8);
        load_random(8'h60, NPIX_B);   // Pixels 60..87, results A0..C7
        run_job(make_cfg(8'h08, 8'h60, 8'ha0, NPIX_B), 1'b1);
        check_memory("long job");

        // Both data sets loaded first so the jobs run back to back
        load_random(8'hd0, 8);
        load_random(8'hd8, NPIX_C);
        load_random(8'h20, 8);
        load_random(8'h28, NPIX_D);
        run_job(make_cfg(8'hd0, 8'hd8, 8'he8, NPIX_C), 1'b1);
        run_job(make_cfg(8'h20, 8'h28, 8'hf4, NPIX_D), 1'b1);
        check_memory("back to back jobs");

        $display("Error counts: %0d mismatches, %0d other failures",
                 mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        other_count++;
        $display("Timeout after %0d cycles, the run did not complete", cycle_count);
        $display("Error counts: %0d mismatches, %0d other failures",
                 mismatch_count, other_count);
        $display("Regression failed");
        $finish;
    end

endmodule

// ==== fused_pointwise.f ====
+incdir+.
fused_pkg.sv
global_mem.sv
gmem_arbiter.sv
fetch_unit.sv
pointwise_mac.sv
pointwise_engine.sv
result_writer.sv
fused_top.sv
tb_clock_gen.sv
fused_tb.sv
